// File: build.f
+incdir+common
common/line_code_pkg.sv
common/time_pkg.sv
line_code/encode_8b10b.sv
line_code/decode_8b10b.sv
time_link/time_sender.sv
time_link/time_receiver.sv
hdl/time_link_top.sv
tests/time_link_tb.sv

// File: Bender.yml
package:
  name: time_link

sources:
  - include_dirs:
      - common
    files:
      - common/line_code_pkg.sv
      - common/time_pkg.sv
      - line_code/encode_8b10b.sv
      - line_code/decode_8b10b.sv
      - time_link/time_sender.sv
      - time_link/time_receiver.sv
      - hdl/time_link_top.sv
  - target: test
    files:
      - tests/time_link_tb.sv

// File: tests/time_link_tb.sv
`timescale 1ns/1ns

module time_link_tb;

   localparam int ACK_LIMIT = 200;
   localparam int SYNC_LIMIT = 200;
   localparam int RANDOM_COUNT = 20;

   logic                   clk;
   logic                   rst;
   logic                   time_req;
   time_pkg::master_time_t time_in;
   logic                   time_ack;
   time_pkg::master_time_t master_time;
   logic                   sync_rcvd;
   logic                   link_err;

   int                     sync_count;
   time_pkg::master_time_t last_time;
   logic                   err_watch;

   time_link_top UUT (
      .clk         (clk),
      .rst         (rst),
      .time_req    (time_req),
      .time_in     (time_in),
      .time_ack    (time_ack),
      .master_time (master_time),
      .sync_rcvd   (sync_rcvd),
      .link_err    (link_err)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #20 clk = ~clk;
   end

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("Regression failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string test_name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected)
      begin
         $display("Fail %s: expected %h, actual %h", test_name, expected, actual);
         fail_run("value mismatch");
      end
   endtask

   // Registered outputs are sampled before they update
   always @(posedge clk)
   begin
      if (sync_rcvd === 1'b1)
      begin
         sync_count = sync_count + 1;
         last_time = master_time;
      end
      if (err_watch && link_err !== 1'b0)
         fail_run("link_err rose on a clean link");
   end

   task automatic wait_ack(input logic level, input int limit, input string what);
      int cycles;
      cycles = 0;
      while (time_ack !== level)
      begin
         if (cycles >= limit)
            fail_run(what);
         else
         begin
            @(negedge clk);
            cycles++;
         end
      end
   endtask

   task automatic wait_sync(input int start, input int limit);
      int cycles;
      cycles = 0;
      while (sync_count == start)
      begin
         if (cycles >= limit)
            fail_run("sync_rcvd never pulsed");
         else
         begin
            @(negedge clk);
            cycles++;
         end
      end
   endtask

   // One full four-phase handshake and a check of the received value
   task automatic run_transfer(input string test_name, input time_pkg::master_time_t value);
      int start;
      start = sync_count;
      @(negedge clk);
      time_in = value;
      time_req = 1'b1;
      wait_ack(1'b1, ACK_LIMIT, "time_ack never rose");
      time_req = 1'b0;
      wait_ack(1'b0, ACK_LIMIT, "time_ack never fell");
      wait_sync(start, SYNC_LIMIT);
      check_value(test_name, value, last_time);
      check_value({test_name, " pulses"}, start + 1, sync_count);
   endtask

   task automatic test_quiet();
      for (int i = 0; i < 200; i++)
      begin
         @(negedge clk);
         check_value("quiet sync_rcvd", 32'd0, {31'd0, sync_rcvd});
         check_value("quiet time_ack", 32'd0, {31'd0, time_ack});
         // Idle commas have aligned the receiver by now
         if (i == 80)
            err_watch = 1'b1;
      end
      check_value("quiet link_err", 32'd0, {31'd0, link_err});
   endtask

   task automatic test_single();
      int start;
      start = sync_count;
      run_transfer("single", 32'h0123_4567);
      repeat (100)
         @(negedge clk);
      check_value("single held", 32'h0123_4567, master_time);
      check_value("single pulses", start + 1, sync_count);
   endtask

   task automatic test_four_phase();
      int start;
      start = sync_count;
      @(negedge clk);
      time_in = 32'h89ab_cdef;
      time_req = 1'b1;
      wait_ack(1'b1, ACK_LIMIT, "time_ack never rose");
      wait_sync(start, SYNC_LIMIT);
      check_value("four_phase", 32'h89ab_cdef, last_time);
      // Request stays up, so no new frame may start
      for (int i = 0; i < 150; i++)
      begin
         @(negedge clk);
         check_value("four_phase ack held", 32'd1, {31'd0, time_ack});
      end
      check_value("four_phase pulses", start + 1, sync_count);
      time_req = 1'b0;
      wait_ack(1'b0, 4, "time_ack never fell after time_req dropped");
   endtask

   task automatic test_control_like();
      time_pkg::master_time_t values [5];
      values[0] = 32'h3cbc_00ff;
      values[1] = 32'hbc3c_ff00;
      values[2] = 32'h3c3c_3c3c;
      values[3] = 32'hbcbc_bcbc;
      values[4] = 32'h00ff_3cbc;
      foreach (values[i])
         run_transfer("control_like", values[i]);
   endtask

   task automatic test_random();
      time_pkg::master_time_t value;
      for (int i = 0; i < RANDOM_COUNT; i++)
      begin
         value = $urandom;
         run_transfer("random", value);
      end
   endtask

   initial
   begin
      void'($urandom(32'he870_5182));
      rst = 1'b1;
      time_req = 1'b0;
      time_in = '0;
      err_watch = 1'b0;
      sync_count = 0;
      repeat (3)
         @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      test_quiet();
      test_single();
      test_four_phase();
      test_control_like();
      test_random();

      $display("Regression passed");
      $finish;
   end

endmodule

// File: hdl/time_link_top.sv
`timescale 1ns/1ns

module time_link_top (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   time_req,
   input  time_pkg::master_time_t time_in,
   output logic                   time_ack,
   output time_pkg::master_time_t master_time,
   output logic                   sync_rcvd,
   output logic                   link_err
);

   // Single wire, one bit per clock
   logic serial_line;

   time_sender sender (
      .clk         (clk),
      .rst         (rst),
      .time_req    (time_req),
      .time_in     (time_in),
      .time_ack    (time_ack),
      .serial_line (serial_line)
   );

   time_receiver receiver (
      .clk         (clk),
      .rst         (rst),
      .serial_in   (serial_line),
      .master_time (master_time),
      .sync_rcvd   (sync_rcvd),
      .link_err    (link_err)
   );

endmodule

// File: time_link/time_receiver.sv
`timescale 1ns/1ns
`include "time_link_cfg.svh"

module time_receiver (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   serial_in,
   output time_pkg::master_time_t master_time,
   output logic                   sync_rcvd,
   output logic                   link_err
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_T0,
      ST_T1,
      ST_T2,
      ST_T3
   } state_t;

   line_code_pkg::symbol_t        shift_reg;
   logic [3:0]                    bit_count;
   logic                          found_comma;
   logic                          set_disp;
   logic                          complete_word;
   logic                          disp_reg;
   logic                          dec_disp;
   line_code_pkg::decode_result_t dec;
   line_code_pkg::code_word_t     word_reg;
   logic                          err_reg;
   state_t                        state;
   logic [7:0]                    held_a;
   logic [7:0]                    held_b;
   logic [7:0]                    held_c;
   time_pkg::time_bytes_t         rx_time;
   time_pkg::master_time_t        time_reg;
   logic                          sync_reg;

   // New bits enter at the top, first bit ends up in bit 0
   always_ff @(posedge clk)
   begin
      shift_reg <= {serial_in, shift_reg[9:1]};
   end

   assign found_comma = (shift_reg == `TIME_LINK_COMMA_NEG) || (shift_reg == `TIME_LINK_COMMA_POS);
   assign set_disp = (shift_reg == `TIME_LINK_COMMA_POS);
   assign complete_word = (bit_count == 4'd9);

   always_ff @(posedge clk)
   begin
      if (rst || found_comma || complete_word)
         bit_count <= 4'd0;
      else
         bit_count <= bit_count + 4'd1;
   end

   decode_8b10b decoder (
      .datain  (shift_reg),
      .dispin  (disp_reg),
      .result  (dec),
      .dispout (dec_disp)
   );

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         disp_reg <= 1'b0;
         err_reg <= 1'b0;
      end
      else if (set_disp)
         disp_reg <= 1'b1;
      else if (complete_word)
         disp_reg <= dec_disp;
      if (!rst && complete_word)
         err_reg <= dec.code_err | dec.disp_err;
   end

   always_ff @(posedge clk)
   begin
      if (complete_word)
         word_reg <= dec.word;
   end

   // Fourth byte comes straight from the word register
   assign rx_time = '{byte_a: held_a, byte_b: held_b, byte_c: held_c, byte_d: word_reg.data};

   always_ff @(posedge clk)
   begin
      sync_reg <= 1'b0;
      if (rst)
         state <= ST_IDLE;
      else if (complete_word)
      begin
         case (state)
            ST_IDLE:
               if (word_reg == `TIME_LINK_HEAD)
                  state <= ST_T0;
            ST_T0:
            begin
               held_a <= word_reg.data;
               state <= ST_T1;
            end
            ST_T1:
            begin
               held_b <= word_reg.data;
               state <= ST_T2;
            end
            ST_T2:
            begin
               held_c <= word_reg.data;
               state <= ST_T3;
            end
            default:
            begin
               time_reg <= rx_time;
               sync_reg <= 1'b1;
               state <= ST_IDLE;
            end
         endcase
      end
   end

   assign master_time = time_reg;
   assign sync_rcvd = sync_reg;
   assign link_err = err_reg;

endmodule

// File: time_link/time_sender.sv
`timescale 1ns/1ns
`include "time_link_cfg.svh"

module time_sender (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   time_req,
   input  time_pkg::master_time_t time_in,
   output logic                   time_ack,
   output logic                   serial_line
);

   // Symbol slots of a frame, data bytes follow the head
   localparam logic [2:0] SEQ_IDLE = 3'd0;
   localparam logic [2:0] SEQ_COMMA = 3'd1;
   localparam logic [2:0] SEQ_HEAD = 3'd2;
   localparam logic [2:0] SEQ_LAST = 3'(SEQ_HEAD + `TIME_LINK_BYTES);

   logic [3:0]                phase;
   logic                      boundary;
   logic [2:0]                seq;
   logic [2:0]                next_seq;
   logic                      disp;
   logic                      enc_disp;
   line_code_pkg::code_word_t next_word;
   line_code_pkg::symbol_t    next_symbol;
   line_code_pkg::symbol_t    shift_reg;
   time_pkg::time_bytes_t     tx_time;

   // Last bit of the current symbol is on the line
   assign boundary = (phase == 4'd9);

   always_ff @(posedge clk)
   begin
      if (rst)
         phase <= 4'd9;
      else if (boundary)
         phase <= 4'd0;
      else
         phase <= phase + 4'd1;
   end

   always_comb
   begin
      if (seq == SEQ_IDLE)
         next_seq = (time_req && !time_ack) ? SEQ_COMMA : SEQ_IDLE;
      else if (seq == SEQ_LAST)
         next_seq = SEQ_IDLE;
      else
         next_seq = seq + 3'd1;
   end

   always_comb
   begin
      case (next_seq)
         SEQ_IDLE, SEQ_COMMA: next_word = `TIME_LINK_IDLE;
         SEQ_HEAD: next_word = `TIME_LINK_HEAD;
         3'd3: next_word = {1'b0, tx_time.byte_a};
         3'd4: next_word = {1'b0, tx_time.byte_b};
         3'd5: next_word = {1'b0, tx_time.byte_c};
         default: next_word = {1'b0, tx_time.byte_d};
      endcase
   end

   encode_8b10b encoder (
      .datain  (next_word),
      .dispin  (disp),
      .dataout (next_symbol),
      .dispout (enc_disp)
   );

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         seq <= SEQ_IDLE;
         disp <= 1'b0;
         shift_reg <= '0;
      end
      else if (boundary)
      begin
         seq <= next_seq;
         disp <= enc_disp;
         shift_reg <= next_symbol;
      end
      else
         shift_reg <= {1'b0, shift_reg[9:1]};
   end

   // Time is taken when the frame comma is loaded
   always_ff @(posedge clk)
   begin
      if (boundary && seq == SEQ_IDLE && next_seq == SEQ_COMMA)
         tx_time <= time_in;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         time_ack <= 1'b0;
      else if (boundary && seq == SEQ_LAST)
         time_ack <= 1'b1;
      else if (!time_req)
         time_ack <= 1'b0;
   end

   assign serial_line = shift_reg[0];

endmodule

// File: line_code/decode_8b10b.sv
`timescale 1ns/1ns

module decode_8b10b (
   input  line_code_pkg::symbol_t        datain,
   input  logic                          dispin,
   output line_code_pkg::decode_result_t result,
   output logic                          dispout
);

   logic [5:0] code6;
   logic [3:0] code4;
   logic [4:0] x;
   logic [2:0] y;
   logic       is_k28;
   logic       err6;
   logic       err4;
   logic       disp_mid;
   logic       need_neg6;
   logic       need_pos6;
   logic       need_neg4;
   logic       need_pos4;

   // Sub-blocks in table order, a and f in the top bits
   always_comb
   begin
      for (int i = 0; i < 6; i++)
         code6[5 - i] = datain[i];
      for (int i = 0; i < 4; i++)
         code4[3 - i] = datain[6 + i];
   end

   always_comb
   begin
      x = 5'd0;
      is_k28 = 1'b0;
      err6 = 1'b0;
      case (code6)
         6'b100111, 6'b011000: x = 5'd0;
         6'b011101, 6'b100010: x = 5'd1;
         6'b101101, 6'b010010: x = 5'd2;
         6'b110001: x = 5'd3;
         6'b110101, 6'b001010: x = 5'd4;
         6'b101001: x = 5'd5;
         6'b011001: x = 5'd6;
         6'b111000, 6'b000111: x = 5'd7;
         6'b111001, 6'b000110: x = 5'd8;
         6'b100101: x = 5'd9;
         6'b010101: x = 5'd10;
         6'b110100: x = 5'd11;
         6'b001101: x = 5'd12;
         6'b101100: x = 5'd13;
         6'b011100: x = 5'd14;
         6'b010111, 6'b101000: x = 5'd15;
         6'b011011, 6'b100100: x = 5'd16;
         6'b100011: x = 5'd17;
         6'b010011: x = 5'd18;
         6'b110010: x = 5'd19;
         6'b001011: x = 5'd20;
         6'b101010: x = 5'd21;
         6'b011010: x = 5'd22;
         6'b111010, 6'b000101: x = 5'd23;
         6'b110011, 6'b001100: x = 5'd24;
         6'b100110: x = 5'd25;
         6'b010110: x = 5'd26;
         6'b110110, 6'b001001: x = 5'd27;
         6'b001110: x = 5'd28;
         6'b101110, 6'b010001: x = 5'd29;
         6'b011110, 6'b100001: x = 5'd30;
         6'b101011, 6'b010100: x = 5'd31;
         6'b001111, 6'b110000:
         begin
            x = 5'd28;
            is_k28 = 1'b1;
         end
         default: err6 = 1'b1;
      endcase
   end

   assign need_neg6 = ($countones(code6) == 4) || (code6 == 6'b111000);
   assign need_pos6 = ($countones(code6) == 2) || (code6 == 6'b000111);
   assign disp_mid = ($countones(code6) == 4) ? 1'b1 :
                     ($countones(code6) == 2) ? 1'b0 : dispin;

   always_comb
   begin
      y = 3'd0;
      err4 = 1'b0;
      if (is_k28)
      begin
         case (code4)
            4'b0110, 4'b1001: y = 3'd1;
            4'b0101, 4'b1010: y = 3'd5;
            default: err4 = 1'b1;
         endcase
      end
      else
      begin
         case (code4)
            4'b1011, 4'b0100: y = 3'd0;
            4'b1001: y = 3'd1;
            4'b0101: y = 3'd2;
            4'b1100, 4'b0011: y = 3'd3;
            4'b1101, 4'b0010: y = 3'd4;
            4'b1010: y = 3'd5;
            4'b0110: y = 3'd6;
            4'b1110, 4'b0001, 4'b0111, 4'b1000: y = 3'd7;
            default: err4 = 1'b1;
         endcase
      end
   end

   // K28 tail polarity follows disparity even when balanced
   assign need_neg4 = is_k28 ? (code4 == 4'b0110 || code4 == 4'b0101)
                             : ($countones(code4) == 3 || code4 == 4'b1100);
   assign need_pos4 = is_k28 ? (code4 == 4'b1001 || code4 == 4'b1010)
                             : ($countones(code4) == 1 || code4 == 4'b0011);

   assign dispout = ($countones(code4) == 3) ? 1'b1 :
                    ($countones(code4) == 1) ? 1'b0 : disp_mid;

   always_comb
   begin
      result.word.is_k = is_k28;
      result.word.data = {y, x};
      result.code_err = err6 | err4;
      result.disp_err = (need_neg6 && dispin) || (need_pos6 && !dispin) ||
                        (need_neg4 && disp_mid) || (need_pos4 && !disp_mid);
   end

endmodule

// File: line_code/encode_8b10b.sv
`timescale 1ns/1ns

module encode_8b10b (
   input  line_code_pkg::code_word_t datain,
   input  logic                      dispin,
   output line_code_pkg::symbol_t    dataout,
   output logic                      dispout
);

   logic [4:0] x;
   logic [2:0] y;
   logic [5:0] code6_neg;
   logic [3:0] code4_neg;
   logic [5:0] code6;
   logic [3:0] code4;
   logic       unbal6;
   logic       unbal4;
   logic       disp_mid;
   logic       alt7;

   assign x = datain.data[4:0];
   assign y = datain.data[7:5];

   // 5b/6b, abcdei for negative running disparity
   always_comb
   begin
      case (x)
         5'd0: code6_neg = 6'b100111;
         5'd1: code6_neg = 6'b011101;
         5'd2: code6_neg = 6'b101101;
         5'd3: code6_neg = 6'b110001;
         5'd4: code6_neg = 6'b110101;
         5'd5: code6_neg = 6'b101001;
         5'd6: code6_neg = 6'b011001;
         5'd7: code6_neg = 6'b111000;
         5'd8: code6_neg = 6'b111001;
         5'd9: code6_neg = 6'b100101;
         5'd10: code6_neg = 6'b010101;
         5'd11: code6_neg = 6'b110100;
         5'd12: code6_neg = 6'b001101;
         5'd13: code6_neg = 6'b101100;
         5'd14: code6_neg = 6'b011100;
         5'd15: code6_neg = 6'b010111;
         5'd16: code6_neg = 6'b011011;
         5'd17: code6_neg = 6'b100011;
         5'd18: code6_neg = 6'b010011;
         5'd19: code6_neg = 6'b110010;
         5'd20: code6_neg = 6'b001011;
         5'd21: code6_neg = 6'b101010;
         5'd22: code6_neg = 6'b011010;
         5'd23: code6_neg = 6'b111010;
         5'd24: code6_neg = 6'b110011;
         5'd25: code6_neg = 6'b100110;
         5'd26: code6_neg = 6'b010110;
         5'd27: code6_neg = 6'b110110;
         5'd28: code6_neg = 6'b001110;
         5'd29: code6_neg = 6'b101110;
         5'd30: code6_neg = 6'b011110;
         default: code6_neg = 6'b101011;
      endcase
      if (datain.is_k)
         code6_neg = 6'b001111;
   end

   assign unbal6 = ($countones(code6_neg) == 4);
   // D.7 is balanced but still flips with disparity
   assign code6 = (dispin && (unbal6 || (x == 5'd7 && !datain.is_k))) ? ~code6_neg : code6_neg;
   assign disp_mid = dispin ^ unbal6;

   // Alternate D.x.7 avoids a run of five
   assign alt7 = disp_mid ? (x == 5'd11 || x == 5'd13 || x == 5'd14)
                          : (x == 5'd17 || x == 5'd18 || x == 5'd20);

   always_comb
   begin
      case (y)
         3'd0: code4_neg = 4'b1011;
         3'd1: code4_neg = 4'b1001;
         3'd2: code4_neg = 4'b0101;
         3'd3: code4_neg = 4'b1100;
         3'd4: code4_neg = 4'b1101;
         3'd5: code4_neg = 4'b1010;
         3'd6: code4_neg = 4'b0110;
         default: code4_neg = alt7 ? 4'b0111 : 4'b1110;
      endcase
      // Only K28.1 and K28.5 are used on this link
      if (datain.is_k)
         code4_neg = (y == 3'd1) ? 4'b0110 : 4'b0101;
   end

   assign unbal4 = ($countones(code4_neg) == 3);
   assign code4 = (disp_mid && (unbal4 || datain.is_k || y == 3'd3)) ? ~code4_neg : code4_neg;
   assign dispout = disp_mid ^ unbal4;

   always_comb
   begin
      for (int i = 0; i < 6; i++)
         dataout[i] = code6[5 - i];
      for (int i = 0; i < 4; i++)
         dataout[6 + i] = code4[3 - i];
   end

endmodule

// File: common/time_pkg.sv
package time_pkg;

   typedef logic [31:0] master_time_t;

   // Same bits as master_time_t, split for the link
   typedef struct packed {
      logic [7:0] byte_a;
      logic [7:0] byte_b;
      logic [7:0] byte_c;
      logic [7:0] byte_d;
   } time_bytes_t;

endpackage

// File: common/line_code_pkg.sv
package line_code_pkg;

   // One 10-bit line symbol, bit 0 goes out first
   typedef logic [9:0] symbol_t;

   // Byte plus control flag, K28.5 is {1'b1, 8'hbc}
   typedef struct packed {
      logic       is_k;
      logic [7:0] data;
   } code_word_t;

   typedef struct packed {
      code_word_t word;
      logic       code_err;
      logic       disp_err;
   } decode_result_t;

endpackage

// File: common/time_link_cfg.svh
`ifndef TIME_LINK_CFG_SVH
`define TIME_LINK_CFG_SVH

// K28.5 symbol that leaves negative disparity
`define TIME_LINK_COMMA_NEG 10'h283

// K28.5 symbol that leaves positive disparity
`define TIME_LINK_COMMA_POS 10'h17c

// K28.1, marks the start of a frame
`define TIME_LINK_HEAD 9'h13c

// K28.5, sent between frames
`define TIME_LINK_IDLE 9'h1bc

`define TIME_LINK_BYTES 4

`endif
